//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= port_afu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
+incdir+src
src/tlp_pkg.sv
src/tlp_stream_if.sv
src/rx_cpl_splitter.sv
src/tag_remapper.sv
src/large_read_engine.sv
src/port_afu_top.sv
test/port_afu_tb.sv

//--- src/large_read_engine.sv
// ==============================
// Large read engine: splits a host command into reads,
// folds the returned data into a byte count and an XOR
// checksum, then writes the result to the report address
// ==============================
`timescale 1ns/100ps
`include "tlp_macros.svh"

module large_read_engine
   import tlp_pkg::*;
(
   input  logic         uclk_usr,
   input  logic         uclk_rst_n,
   tlp_stream_if.sink   cmd_in,
   tlp_stream_if.sink   cpl_in,
   tlp_stream_if.source tx_out
);

   localparam logic [2:0] ST_IDLE     = 3'd0;
   localparam logic [2:0] ST_RD       = 3'd1;
   localparam logic [2:0] ST_WAIT     = 3'd2;
   localparam logic [2:0] ST_RPT_HDR  = 3'd3;
   localparam logic [2:0] ST_RPT_DATA = 3'd4;

   logic [2:0]  state;
   logic        cmd_sop;
   logic        cmd_is_wr_q;
   tlp_hdr_u    cmd_hdr;
   tlp_cmd_t    cmd_word;
   logic        cpl_sop;

   // Command registers
   logic [31:0] rd_addr;
   logic [15:0] rd_left;
   logic [15:0] total_len;
   logic [15:0] rpt_addr;
   logic [15:0] rd_len;

   // Completion totals
   logic [15:0] rcv_bytes;
   logic [31:0] csum;

   tlp_hdr_u    tx_hdr;

   assign cmd_hdr  = cmd_in.data;
   assign cmd_word = cmd_in.data;

   // Only one command is taken until its report has left
   assign cmd_in.ready = (state == ST_IDLE);
   // Completions are never pushed back
   assign cpl_in.ready = 1'b1;

   // Each read is a full maximum sized piece or whatever remains
   assign rd_len = (rd_left > 16'(`TLP_MAX_READ_BYTES)) ?
                   16'(`TLP_MAX_READ_BYTES) : rd_left;

   // ==============================
   // Transmit beats
   // ==============================

   always_comb begin
      tx_hdr = '0;
      if (state == ST_RD) begin
         // Every piece keeps local tag 0 so all data maps to this command
         tx_hdr.req.fmt_type = `TLP_FMT_MEM_RD;
         tx_hdr.req.length   = rd_len;
         tx_hdr.req.addr     = rd_addr;
      end else begin
         tx_hdr.req.fmt_type = `TLP_FMT_MEM_WR;
         tx_hdr.req.length   = 16'd8;
         tx_hdr.req.addr     = {16'h0, rpt_addr};
      end
   end

   assign tx_out.valid = (state == ST_RD) || (state == ST_RPT_HDR) ||
                         (state == ST_RPT_DATA);
   // A read is header only, the report has one payload beat
   assign tx_out.last  = (state != ST_RPT_HDR);
   assign tx_out.data  = (state == ST_RPT_DATA) ? {16'h0, rcv_bytes, csum} : tx_hdr;

   // ==============================
   // Control
   // ==============================

   always_ff @(posedge uclk_usr) begin
      if (!uclk_rst_n) begin
         state       <= ST_IDLE;
         cmd_sop     <= 1'b1;
         cmd_is_wr_q <= 1'b0;
         cpl_sop     <= 1'b1;
         rcv_bytes   <= '0;
         csum        <= '0;
      end else begin
         if (cmd_in.valid && cmd_in.ready) begin
            cmd_sop <= cmd_in.last;
            if (cmd_sop) begin
               cmd_is_wr_q <= (cmd_hdr.req.fmt_type == `TLP_FMT_MEM_WR);
            end
         end

         // Header beats are skipped, every payload beat is counted
         if (cpl_in.valid) begin
            cpl_sop <= cpl_in.last;
            if (!cpl_sop) begin
               rcv_bytes <= rcv_bytes + 16'd8;
               csum      <= csum ^ cpl_in.data[31:0];
            end
         end

         case (state)
            ST_IDLE: begin
               // The payload beat of a write is the command itself
               if (cmd_in.valid && !cmd_sop && cmd_in.last && cmd_is_wr_q) begin
                  state <= ST_RD;
               end
            end
            ST_RD: begin
               if (tx_out.ready && (rd_left == rd_len)) begin
                  state <= ST_WAIT;
               end
            end
            ST_WAIT: begin
               if (rcv_bytes == total_len) begin
                  state <= ST_RPT_HDR;
               end
            end
            ST_RPT_HDR: begin
               if (tx_out.ready) begin
                  state <= ST_RPT_DATA;
               end
            end
            ST_RPT_DATA: begin
               // Report sent, so the totals start over for the next command
               if (tx_out.ready) begin
                  state     <= ST_IDLE;
                  rcv_bytes <= '0;
                  csum      <= '0;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // Command registers load from the payload beat and step as each read leaves
   always_ff @(posedge uclk_usr) begin
      if (cmd_in.valid && cmd_in.ready && !cmd_sop) begin
         rd_addr   <= cmd_word.start_addr;
         rd_left   <= cmd_word.length;
         total_len <= cmd_word.length;
         rpt_addr  <= cmd_word.report_addr;
      end else if (state == ST_RD && tx_out.ready) begin
         rd_addr <= rd_addr + 32'(rd_len);
         rd_left <= rd_left - rd_len;
      end
   end

endmodule

//--- src/port_afu_top.sv
// ==============================
// Port top level: receive splitter, tag remapper and
// large read engine behind plain stream ports
// ==============================
`timescale 1ns/100ps
`include "tlp_macros.svh"

module port_afu_top
   import tlp_pkg::*;
(
   input  logic                   uclk_usr,
   input  logic                   uclk_rst_n,

   // Receive stream from the host
   input  logic                   rx_valid,
   input  logic                   rx_last,
   input  logic [`TLP_DATA_W-1:0] rx_data,
   output logic                   rx_ready,

   // Transmit stream to the host
   output logic                   tx_valid,
   output logic                   tx_last,
   output logic [`TLP_DATA_W-1:0] tx_data,
   input  logic                   tx_ready
);

   // ==============================
   // Streams
   // ==============================

   // Host receive stream before the splitter
   tlp_stream_if rx_if ();
   // Index 0 is before the remapper, index 1 after it
   tlp_stream_if cpl_if [2] ();
   // Requests from the host, carrying the commands
   tlp_stream_if req_if ();
   // Index 0 leaves the engine, index 1 goes to the host
   tlp_stream_if tx_if [2] ();

   assign rx_if.valid = rx_valid;
   assign rx_if.last  = rx_last;
   assign rx_if.data  = rx_data;
   assign rx_ready    = rx_if.ready;

   assign tx_valid       = tx_if[1].valid;
   assign tx_last        = tx_if[1].last;
   assign tx_data        = tx_if[1].data;
   assign tx_if[1].ready = tx_ready;

   // ==============================
   // Blocks
   // ==============================

   rx_cpl_splitter splitter (
      .uclk_usr   (uclk_usr),
      .uclk_rst_n (uclk_rst_n),
      .rx_in      (rx_if),
      .cpl_out    (cpl_if[0]),
      .req_out    (req_if)
   );

   tag_remapper remapper (
      .uclk_usr   (uclk_usr),
      .uclk_rst_n (uclk_rst_n),
      .tx_in      (tx_if[0]),
      .tx_out     (tx_if[1]),
      .cpl_in     (cpl_if[0]),
      .cpl_out    (cpl_if[1])
   );

   large_read_engine engine (
      .uclk_usr   (uclk_usr),
      .uclk_rst_n (uclk_rst_n),
      .cmd_in     (req_if),
      .cpl_in     (cpl_if[1]),
      .tx_out     (tx_if[0])
   );

endmodule

//--- src/rx_cpl_splitter.sv
// ==============================
// Receive splitter: completions go to one output and
// all other packets to the other, each through a
// one-deep registered stage
// ==============================
`timescale 1ns/100ps
`include "tlp_macros.svh"

module rx_cpl_splitter
   import tlp_pkg::*;
(
   input  logic         uclk_usr,
   input  logic         uclk_rst_n,
   tlp_stream_if.sink   rx_in,
   tlp_stream_if.source cpl_out,
   tlp_stream_if.source req_out
);

   // Stage 0 carries completions, stage 1 everything else
   logic                   sop;
   logic                   is_cpl;
   logic                   is_cpl_q;
   tlp_hdr_u               in_hdr;
   logic [1:0]             stage_sel;
   logic [1:0]             stage_in_ready;
   logic [1:0]             stage_out_ready;
   logic [1:0]             stage_valid;
   logic [1:0]             stage_last;
   logic [`TLP_DATA_W-1:0] stage_data [2];

   // ==============================
   // Packet classification
   // ==============================

   // fmt_type sits in the same place in both views, so the header
   // can be tested before it is known how to decode the rest
   assign in_hdr = rx_in.data;
   assign is_cpl = sop ? tlp_is_completion(in_hdr.cpl.fmt_type) : is_cpl_q;
   assign stage_sel = {~is_cpl, is_cpl};

   // The decision taken at the header holds until the last beat
   always_ff @(posedge uclk_usr) begin
      if (!uclk_rst_n) begin
         sop      <= 1'b1;
         is_cpl_q <= 1'b0;
      end else if (rx_in.valid && rx_in.ready) begin
         sop      <= rx_in.last;
         is_cpl_q <= is_cpl;
      end
   end

   // The input only waits on the stage that the packet is bound for
   assign rx_in.ready = is_cpl ? stage_in_ready[0] : stage_in_ready[1];

   // ==============================
   // Output stages
   // ==============================

   for (genvar i = 0; i < 2; i++) begin : g_stage
      // A full stage still accepts when its beat leaves in the same cycle
      assign stage_in_ready[i] = !stage_valid[i] || stage_out_ready[i];

      always_ff @(posedge uclk_usr) begin
         if (!uclk_rst_n) begin
            stage_valid[i] <= 1'b0;
         end else if (rx_in.valid && stage_sel[i] && stage_in_ready[i]) begin
            stage_valid[i] <= 1'b1;
         end else if (stage_out_ready[i]) begin
            stage_valid[i] <= 1'b0;
         end
      end

      always_ff @(posedge uclk_usr) begin
         if (rx_in.valid && stage_sel[i] && stage_in_ready[i]) begin
            stage_last[i] <= rx_in.last;
            stage_data[i] <= rx_in.data;
         end
      end
   end

   assign cpl_out.valid      = stage_valid[0];
   assign cpl_out.last       = stage_last[0];
   assign cpl_out.data       = stage_data[0];
   assign stage_out_ready[0] = cpl_out.ready;

   assign req_out.valid      = stage_valid[1];
   assign req_out.last       = stage_last[1];
   assign req_out.data       = stage_data[1];
   assign stage_out_ready[1] = req_out.ready;

endmodule

//--- src/tag_remapper.sv
// ==============================
// Bus tag remapper: gives each read request a free bus
// tag on transmit and puts the local tag back into the
// matching completion on receive
// ==============================
`timescale 1ns/100ps
`include "tlp_macros.svh"

module tag_remapper
   import tlp_pkg::*;
(
   input  logic         uclk_usr,
   input  logic         uclk_rst_n,
   tlp_stream_if.sink   tx_in,
   tlp_stream_if.source tx_out,
   tlp_stream_if.sink   cpl_in,
   tlp_stream_if.source cpl_out
);

   localparam int TAG_W = $clog2(`TLP_TAG_COUNT);

   // One bit per bus tag, set while the tag is free
   logic [`TLP_TAG_COUNT-1:0] tag_free;
   // Local tag of the read that holds each bus tag
   logic [7:0]                local_tag [`TLP_TAG_COUNT];

   logic                      tx_sop;
   tlp_hdr_u                  tx_hdr;
   tlp_hdr_u                  tx_hdr_new;
   logic                      tx_is_rd;
   logic                      tx_go;
   logic                      any_free;
   logic [TAG_W-1:0]          free_idx;
   logic                      tag_held;
   logic [TAG_W-1:0]          held_idx;
   logic [TAG_W-1:0]          tx_idx;

   logic                      cpl_sop;
   tlp_hdr_u                  cpl_hdr;
   tlp_hdr_u                  cpl_hdr_new;
   logic [TAG_W-1:0]          cpl_tag;
   logic [TAG_W-1:0]          cpl_tag_q;

   // ==============================
   // Transmit path
   // ==============================

   assign tx_hdr   = tx_in.data;
   assign tx_is_rd = tx_sop && tlp_is_mem_read(tx_hdr.req.fmt_type);

   // Lowest free bus tag, scanning down so the smallest index wins
   always_comb begin
      any_free = 1'b0;
      free_idx = '0;
      for (int i = `TLP_TAG_COUNT - 1; i >= 0; i--) begin
         if (tag_free[i]) begin
            any_free = 1'b1;
            free_idx = i[TAG_W-1:0];
         end
      end
   end

   // A stalled read header keeps the tag it was first offered with,
   // even when a lower tag is freed meanwhile
   assign tx_idx = tag_held ? held_idx : free_idx;

   // A read header with no tag left is held back in both directions
   assign tx_go = !tx_is_rd || any_free;

   always_comb begin
      tx_hdr_new = tx_hdr;
      tx_hdr_new.req.tag = 8'(tx_idx);
   end

   assign tx_out.valid = tx_in.valid && tx_go;
   assign tx_out.last  = tx_in.last;
   assign tx_out.data  = tx_is_rd ? tx_hdr_new : tx_in.data;
   assign tx_in.ready  = tx_out.ready && tx_go;

   // ==============================
   // Completion path
   // ==============================

   assign cpl_hdr = cpl_in.data;

   // The header names the bus tag; later beats reuse the one captured
   assign cpl_tag = cpl_sop ? cpl_hdr.cpl.tag[TAG_W-1:0] : cpl_tag_q;

   always_comb begin
      cpl_hdr_new = cpl_hdr;
      cpl_hdr_new.cpl.tag = local_tag[cpl_tag];
   end

   assign cpl_out.valid = cpl_in.valid;
   assign cpl_out.last  = cpl_in.last;
   assign cpl_out.data  = cpl_sop ? cpl_hdr_new : cpl_in.data;
   assign cpl_in.ready  = cpl_out.ready;

   // ==============================
   // Tag state
   // ==============================

   always_ff @(posedge uclk_usr) begin
      if (!uclk_rst_n) begin
         tag_free <= '1;
         tx_sop   <= 1'b1;
         cpl_sop  <= 1'b1;
         tag_held <= 1'b0;
      end else begin
         tag_held <= tx_out.valid && !tx_out.ready;
         if (tx_in.valid && tx_in.ready) begin
            tx_sop <= tx_in.last;
         end
         if (cpl_in.valid && cpl_in.ready) begin
            cpl_sop <= cpl_in.last;
         end
         // A freed tag is always busy, so it never collides with the
         // tag being handed out in the same cycle
         if (cpl_in.valid && cpl_in.ready && cpl_in.last) begin
            tag_free[cpl_tag] <= 1'b1;
         end
         if (tx_in.valid && tx_in.ready && tx_is_rd) begin
            tag_free[tx_idx] <= 1'b0;
         end
      end
   end

   always_ff @(posedge uclk_usr) begin
      held_idx <= tx_idx;
      if (tx_in.valid && tx_in.ready && tx_is_rd) begin
         local_tag[tx_idx] <= tx_hdr.req.tag;
      end
      if (cpl_in.valid && cpl_in.ready && cpl_sop) begin
         cpl_tag_q <= cpl_tag;
      end
   end

endmodule

//--- src/tlp_macros.svh
// ==============================
// Stream width, bus tag pool size, largest read size
// and the fmt_type codes of the TLP headers
// ==============================
`ifndef TLP_MACROS_SVH
`define TLP_MACROS_SVH

// One beat holds one header word or one payload word
`define TLP_DATA_W 64

// Size of the bus tag pool, which bounds the reads in flight
`define TLP_TAG_COUNT 8

// Largest single read request, eight payload beats
`define TLP_MAX_READ_BYTES 64

// Header fmt_type codes
`define TLP_FMT_MEM_RD 8'h20
`define TLP_FMT_MEM_WR 8'h60
`define TLP_FMT_CPL_D  8'h4a

`endif

//--- src/tlp_pkg.sv
// ==============================
// TLP header views and their union, the command payload
// word and the fmt_type classification helpers
// ==============================
`include "tlp_macros.svh"

package tlp_pkg;

   // ==============================
   // Header word views
   // ==============================

   // Request view of a header word, as sent for reads and writes
   typedef struct packed {
      logic [7:0]  fmt_type;
      logic [7:0]  tag;
      logic [15:0] length;
      logic [31:0] addr;
   } tlp_req_hdr_t;

   // Completion view of the same word
   // fmt_type and tag share their positions with the request view
   typedef struct packed {
      logic [7:0]  fmt_type;
      logic [7:0]  tag;
      logic [15:0] byte_count;
      logic [31:0] lower_addr;
   } tlp_cpl_hdr_t;

   // One header word, decoded either way once its fmt_type is known
   typedef union packed {
      tlp_req_hdr_t req;
      tlp_cpl_hdr_t cpl;
   } tlp_hdr_u;

   // Command payload beat sent by the host with a memory write
   typedef struct packed {
      logic [31:0] start_addr;
      logic [15:0] length;
      logic [15:0] report_addr;
   } tlp_cmd_t;

   // ==============================
   // fmt_type helpers
   // ==============================

   // True for a completion carrying data
   function automatic logic tlp_is_completion(input logic [7:0] fmt_type);
      return fmt_type == `TLP_FMT_CPL_D;
   endfunction

   // True for a memory read request, the only packet that takes a bus tag
   function automatic logic tlp_is_mem_read(input logic [7:0] fmt_type);
      return fmt_type == `TLP_FMT_MEM_RD;
   endfunction

endpackage

//--- src/tlp_stream_if.sv
// ==============================
// Valid/ready stream of TLP beats with last marking
// the end of a packet, plus source and sink views
// ==============================
`timescale 1ns/100ps
`include "tlp_macros.svh"

interface tlp_stream_if;

   logic                   valid;
   logic                   ready;
   logic                   last;
   logic [`TLP_DATA_W-1:0] data;

   // The source offers a beat and holds it until ready is seen
   modport source (
      output valid,
      output last,
      output data,
      input  ready
   );

   // The sink only answers with ready
   modport sink (
      input  valid,
      input  last,
      input  data,
      output ready
   );

endinterface

//--- test/port_afu_tb.sv
// ==============================
// Testbench for the port top level: host model that
// sends commands from the test data file, answers reads
// out of order, checks the transmit stream, timeout
// ==============================
`timescale 1ns/100ps
`include "tlp_macros.svh"

module port_afu_tb
   import tlp_pkg::*;
();

   logic                   uclk_usr = 1'b0;
   logic                   uclk_rst_n;
   logic                   rx_valid;
   logic                   rx_last;
   logic [`TLP_DATA_W-1:0] rx_data;
   logic                   rx_ready;
   logic                   tx_valid;
   logic                   tx_last;
   logic [`TLP_DATA_W-1:0] tx_data;
   logic                   tx_ready = 1'b0;

   // Tests as read from the data file
   string                  names [$];
   logic [31:0]            starts [$];
   logic [31:0]            lens [$];
   logic [31:0]            rpts [$];

   // Current test and the state expected from it
   string                  cur_name;
   logic [31:0]            cur_start;
   logic [15:0]            cur_len;
   logic [15:0]            cur_rpt;
   logic [31:0]            exp_addr;
   logic [15:0]            exp_left;
   logic [31:0]            exp_csum;
   bit                     hold;
   int                     reads_seen;
   int                     reports;

   // Reads seen on tx and not answered yet
   logic [7:0]             pend_tag [$];
   logic [31:0]            pend_addr [$];
   logic [15:0]            pend_len [$];
   logic [63:0]            pkt_q [$];

   logic                   mon_sop;
   logic                   stalled;
   logic                   held_last;
   logic [63:0]            held_data;
   int                     errors = 0;
   int                     failed_tests = 0;
   int                     cycles = 0;
   int                     cycle_limit = 0;

   port_afu_top uut (
      .uclk_usr   (uclk_usr),
      .uclk_rst_n (uclk_rst_n),
      .rx_valid   (rx_valid),
      .rx_last    (rx_last),
      .rx_data    (rx_data),
      .rx_ready   (rx_ready),
      .tx_valid   (tx_valid),
      .tx_last    (tx_last),
      .tx_data    (tx_data),
      .tx_ready   (tx_ready)
   );

   always #20 uclk_usr = ~uclk_usr;

   // The host takes tx traffic at random
   always @(negedge uclk_usr) begin
      tx_ready <= (($urandom % 3) != 0);
   end

   always @(posedge uclk_usr) begin
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
         $display("Some tests failed");
         $finish;
      end
   end

   // ==============================
   // Expected values
   // ==============================

   // XOR of the low words of all payload beats, each beat holding
   // its own byte address
   function automatic logic [31:0] expected_checksum(input logic [31:0] start,
                                                     input logic [15:0] len);
      logic [31:0] acc;
      int          k;
      acc = '0;
      for (k = 0; k < int'(len) / 8; k++) begin
         acc = acc ^ (start + 32'(8 * k));
      end
      return acc;
   endfunction

   // ==============================
   // Transmit monitor
   // ==============================

   task automatic check_tx_header();
      tlp_hdr_u    hdr;
      logic [15:0] exp_len;
      bit          dup;
      hdr = tx_data;
      assert (hdr.req.fmt_type == `TLP_FMT_MEM_RD || hdr.req.fmt_type == `TLP_FMT_MEM_WR)
      else begin
         $display("[ERROR] %s: fmt_type, expected %h or %h, actual %h", cur_name,
                  `TLP_FMT_MEM_RD, `TLP_FMT_MEM_WR, hdr.req.fmt_type);
         errors++;
      end
      if (hdr.req.fmt_type == `TLP_FMT_MEM_RD) begin
         // Full pieces first, then whatever is left
         if (exp_left >= 16'(`TLP_MAX_READ_BYTES)) begin
            exp_len = 16'(`TLP_MAX_READ_BYTES);
         end else begin
            exp_len = exp_left;
         end
         assert (hdr.req.addr == exp_addr) else begin
            $display("[ERROR] %s: read address, expected %h, actual %h", cur_name,
                     exp_addr, hdr.req.addr);
            errors++;
         end
         assert (hdr.req.length == exp_len) else begin
            $display("[ERROR] %s: read length, expected %0d, actual %0d", cur_name,
                     exp_len, hdr.req.length);
            errors++;
         end
         assert (tx_last) else begin
            $display("A read request header in %s did not carry last", cur_name);
            errors++;
         end
         dup = 1'b0;
         foreach (pend_tag[i]) begin
            if (pend_tag[i] == hdr.req.tag) begin
               dup = 1'b1;
            end
         end
         assert (!dup) else begin
            $display("Bus tag %0d was reused in %s while its read was unanswered",
                     hdr.req.tag, cur_name);
            errors++;
         end
         pend_tag.push_back(hdr.req.tag);
         pend_addr.push_back(hdr.req.addr);
         pend_len.push_back(hdr.req.length);
         assert (pend_tag.size() <= `TLP_TAG_COUNT) else begin
            $display("More than %0d reads were outstanding in %s", `TLP_TAG_COUNT, cur_name);
            errors++;
         end
         exp_addr = exp_addr + 32'(exp_len);
         exp_left = exp_left - exp_len;
         reads_seen++;
      end else if (hdr.req.fmt_type == `TLP_FMT_MEM_WR) begin
         assert (exp_left == 0 && pend_tag.size() == 0 && reports == 0) else begin
            $display("The report write in %s came early or more than once", cur_name);
            errors++;
         end
         assert (hdr.req.addr == {16'h0, cur_rpt}) else begin
            $display("[ERROR] %s: report address, expected %h, actual %h", cur_name,
                     {16'h0, cur_rpt}, hdr.req.addr);
            errors++;
         end
         assert (hdr.req.length == 16'd8 && !tx_last) else begin
            $display("The report write header in %s does not announce one payload beat",
                     cur_name);
            errors++;
         end
      end
   endtask

   // Byte count in the upper half, low checksum word in the lower half
   task automatic check_report_data();
      logic [63:0] exp_word;
      exp_word = {16'h0, cur_len, exp_csum};
      assert (tx_data == exp_word) else begin
         $display("[ERROR] %s: report data, expected %h, actual %h", cur_name,
                  exp_word, tx_data);
         errors++;
      end
      reports++;
   endtask

   always @(posedge uclk_usr) begin
      if (!uclk_rst_n) begin
         mon_sop = 1'b1;
         stalled = 1'b0;
      end else begin
         // A beat that was offered and not taken comes back unchanged
         if (stalled) begin
            assert (tx_valid && tx_last == held_last && tx_data == held_data) else begin
               $display("[ERROR] %s: stalled tx beat, expected %h, actual %h", cur_name,
                        held_data, tx_data);
               errors++;
            end
         end
         stalled   = tx_valid && !tx_ready;
         held_last = tx_last;
         held_data = tx_data;
         if (tx_valid && tx_ready) begin
            if (mon_sop) begin
               check_tx_header();
            end else begin
               check_report_data();
            end
            mon_sop = tx_last;
         end
      end
   end

   // ==============================
   // Host model
   // ==============================

   // Sends pkt_q on rx, starting and ending on a falling edge
   task automatic send_packet();
      int i;
      for (i = 0; i < pkt_q.size(); i++) begin
         rx_valid = 1'b1;
         rx_last  = (i == pkt_q.size() - 1);
         rx_data  = pkt_q[i];
         do @(posedge uclk_usr); while (!rx_ready);
         @(negedge uclk_usr);
      end
      rx_valid = 1'b0;
      rx_last  = 1'b0;
   endtask

   // Answers one outstanding read, picked at random
   task automatic answer_read();
      int          idx;
      int          delay;
      int          i;
      tlp_hdr_u    hdr;
      logic [31:0] addr;
      logic [15:0] len;
      idx   = int'($urandom % pend_tag.size());
      addr  = pend_addr[idx];
      len   = pend_len[idx];
      delay = int'($urandom % 4);
      // With the pool empty the engine is left waiting for a while
      if (pend_tag.size() >= `TLP_TAG_COUNT) begin
         delay = delay + 8;
      end
      repeat (delay + 1) @(negedge uclk_usr);
      hdr                = '0;
      hdr.cpl.fmt_type   = `TLP_FMT_CPL_D;
      hdr.cpl.tag        = pend_tag[idx];
      hdr.cpl.byte_count = len;
      hdr.cpl.lower_addr = addr;
      pkt_q.delete();
      pkt_q.push_back(hdr);
      for (i = 0; i < int'(len) / 8; i++) begin
         pkt_q.push_back(64'(addr) + 64'(8 * i));
      end
      send_packet();
      pend_tag.delete(idx);
      pend_addr.delete(idx);
      pend_len.delete(idx);
   endtask

   task automatic run_test(input int t);
      tlp_hdr_u hdr;
      tlp_cmd_t cmd;
      int       errs_before;
      string    verdict;
      cur_name    = names[t];
      cur_start   = starts[t];
      cur_len     = lens[t][15:0];
      cur_rpt     = rpts[t][15:0];
      exp_addr    = cur_start;
      exp_left    = cur_len;
      exp_csum    = expected_checksum(cur_start, cur_len);
      hold        = (cur_len > 16'(`TLP_TAG_COUNT * `TLP_MAX_READ_BYTES));
      reads_seen  = 0;
      reports     = 0;
      errs_before = errors;
      // Command packet: a write header and one command word
      hdr             = '0;
      hdr.req.fmt_type = `TLP_FMT_MEM_WR;
      hdr.req.length  = 16'd8;
      cmd.start_addr  = cur_start;
      cmd.length      = cur_len;
      cmd.report_addr = cur_rpt;
      pkt_q.delete();
      pkt_q.push_back(hdr);
      pkt_q.push_back(cmd);
      send_packet();
      // Long commands fill the tag pool before any read is answered
      while (reports == 0) begin
         if (pend_tag.size() > 0 &&
             (exp_left == 0 || pend_tag.size() >= `TLP_TAG_COUNT ||
              (!hold && ($urandom % 4) == 0))) begin
            answer_read();
         end else begin
            @(negedge uclk_usr);
         end
      end
      repeat (4) @(negedge uclk_usr);
      if (errors == errs_before) begin
         verdict = "ok";
      end else begin
         verdict = "FAILED";
         failed_tests++;
      end
      $display("Test %s: %0d reads, %0d bytes, %s", cur_name, reads_seen, cur_len, verdict);
   endtask

   // Lines that do not hold four fields are comments
   task automatic load_tests(output bit ok);
      int          fd;
      int          cnt;
      int          beats;
      string       line;
      string       nm;
      logic [31:0] a;
      logic [31:0] l;
      logic [31:0] r;
      ok    = 1'b0;
      beats = 0;
      fd    = $fopen("test/port_afu_tests.txt", "r");
      if (fd != 0) begin
         while ($fgets(line, fd) != 0) begin
            cnt = $sscanf(line, "%s %h %d %h", nm, a, l, r);
            if (cnt == 4) begin
               names.push_back(nm);
               starts.push_back(a);
               lens.push_back(l);
               rpts.push_back(r);
               beats = beats + int'(l[15:0]) / 8;
            end
         end
         $fclose(fd);
         cycle_limit = 200 * names.size() + 40 * beats;
         ok = (names.size() > 0);
      end
   endtask

   // ==============================
   // Main sequence
   // ==============================

   initial begin
      bit ok;
      int t;
      void'($urandom(32'h62f2));
      uclk_rst_n = 1'b0;
      rx_valid   = 1'b0;
      rx_last    = 1'b0;
      rx_data    = '0;
      load_tests(ok);
      if (!ok) begin
         $display("The test data file could not be read or holds no tests");
         $display("Some tests failed");
         $finish;
      end else begin
         repeat (10) @(negedge uclk_usr);
         uclk_rst_n = 1'b1;
         for (t = 0; t < names.size(); t++) begin
            run_test(t);
         end
         $display("Summary: %0d tests, %0d with errors, %0d errors in total",
                  names.size(), failed_tests, errors);
         if (errors == 0) begin
            $display("All tests passed");
         end else begin
            $display("Some tests failed");
         end
         $finish;
      end
   end

endmodule

//--- test/port_afu_tests.txt
# columns: name, start address (hex), length in bytes (decimal), report address (hex)
# Lengths are nonzero multiples of 8, start addresses are 8-byte aligned
single_beat       00001000     8  0100
two_beats         00001100    16  0108
one_full_read     00002000    64  0110
full_plus_one     00003000    72  0118
two_full_reads    00004000   128  0120
odd_tail          00005008   200  0128
three_reads       00006000   192  0130
offset_start      00007038    64  0138
crossing_64k      0000fff8   136  0140
seven_reads       00010000   448  0148
eight_reads       00020000   512  0150
nine_reads        00030000   520  0158
pool_refill       00040000   576  0160
ten_reads_tail    00050010   616  0168
high_address      80000000   256  0170
top_of_space      fffff800  1024  0178
sixteen_reads     00060000  1024  0180
long_2k           00070000  2048  0188
long_tail         00080008  1000  0190
short_after_long  00090000    24  0198
zero_rpt_addr     000a0000    40  0000
max_rpt_addr      000b0000    96  fff8
long_4k           000c0000  4096  01a0
mixed_tail        000d0100   328  01a8
last_single       000e0000     8  01b0
